/* src.f */
source/pulse_gen_pkg.sv
source/pulse_cfg_if.sv
source/pulse_regs.sv
source/pulse_seq.sv
source/pulse_gen_top.sv
dv/pulse_gen_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = pulse_gen_tb
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
VFLAGS     = --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/pulse_gen_tb.sv */
`timescale 1ns/10ps

module pulse_gen_tb;
    import pulse_gen_pkg::*;

    localparam int BUS_TIMEOUT  = 16;
    localparam int RUN_TIMEOUT  = 2000;
    localparam int DONE_POLLS   = 1000;
    localparam int QUIET_WINDOW = 40;
    localparam int FREE_BURSTS  = 6;
    localparam int RANDOM_ROWS  = 6;

    typedef struct packed {
        cycle_cnt_t  delay;
        cycle_cnt_t  width;
        cycle_cnt_t  repeat_n;
        pulse_word_t phase;
        logic        use_ext;
        logic        ext_en;
    } stim_row_t;

    logic        PULSE_CLK;
    logic        RST;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    logic        EXT_START;
    pulse_word_t pulse_word;
    logic        pulse_ref;

    int          word_count;
    int          burst_count;
    pulse_word_t prev_word;
    pulse_word_t first_words[$];
    stim_row_t   rows[$];

    pulse_gen_top dut_i (
        .PULSE_CLK  (PULSE_CLK),
        .RST        (RST),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .EXT_START  (EXT_START),
        .pulse_word (pulse_word),
        .pulse_ref  (pulse_ref)
    );

    always #5 PULSE_CLK = ~PULSE_CLK;

    // ----------------------------------------
    // Error handling
    // ----------------------------------------
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input wb_data_t actual,
                               input wb_data_t expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            stop_run("Value check failed");
        end
    endtask

    // ----------------------------------------
    // Wishbone master
    // ----------------------------------------
    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        int   waited;
        logic got_ack;
        got_ack  = 1'b0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        for (waited = 0; waited < BUS_TIMEOUT && !got_ack; waited++) begin
            @(posedge PULSE_CLK);
            #1;
            got_ack = wb_ack;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!got_ack) begin
            stop_run("Timeout waiting for Wishbone ack on a write");
        end
    endtask

    task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
        int   waited;
        logic got_ack;
        got_ack = 1'b0;
        data    = '0;
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = 1'b0;
        wb_adr  = addr;
        for (waited = 0; waited < BUS_TIMEOUT && !got_ack; waited++) begin
            @(posedge PULSE_CLK);
            #1;
            got_ack = wb_ack;
            data    = wb_dat_r;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (!got_ack) begin
            stop_run("Timeout waiting for Wishbone ack on a read");
        end
    endtask

    task automatic read_expect(input wb_addr_t addr, input wb_data_t expected,
                               input string name);
        wb_data_t rdata;
        bus_read(addr, rdata);
        check_value(name, rdata, expected);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge PULSE_CLK);
            #1;
        end
    endtask

    // Run monitor sampled on the falling edge
    always @(negedge PULSE_CLK) begin
        if (!RST) begin
            if (pulse_word != 4'h0) begin
                word_count = word_count + 1;
                if (prev_word == 4'h0) begin
                    burst_count = burst_count + 1;
                    first_words.push_back(pulse_word);
                    check_value("pulse_ref", {31'd0, pulse_ref}, 32'd1);
                end
            end
            prev_word = pulse_word;
        end
    end

    task automatic clear_monitor();
        word_count  = 0;
        burst_count = 0;
        first_words.delete();
    endtask

    task automatic wait_for_bursts(input int n);
        int waited;
        for (waited = 0; waited < RUN_TIMEOUT && burst_count < n; waited++) begin
            idle_cycles(1);
        end
        if (burst_count < n) begin
            stop_run("Timeout waiting for pulse bursts");
        end
    endtask

    task automatic wait_for_done();
        int       polls;
        wb_data_t status;
        status = '0;
        for (polls = 0; polls < DONE_POLLS && !status[0]; polls++) begin
            bus_read(ADDR_STATUS, status);
        end
        if (!status[0]) begin
            stop_run("Timeout waiting for the done status");
        end
    endtask

    // ----------------------------------------
    // Register checks
    // ----------------------------------------
    task automatic check_reset_values();
        read_expect(ADDR_CTRL,   32'd1, "ctrl version");
        read_expect(ADDR_STATUS, 32'd1, "status done");
        read_expect(ADDR_EN,     32'd0, "en");
        read_expect(ADDR_DELAY,  32'd0, "delay");
        read_expect(ADDR_WIDTH,  32'd0, "width");
        read_expect(ADDR_REPEAT, 32'd1, "repeat");
        read_expect(ADDR_PHASE,  32'd0, "phase");
        read_expect(ADDR_COUNT,  32'd0, "count");
    endtask

    task automatic check_register_access();
        check_reset_values();
        bus_write(ADDR_EN,     32'h0000_0003);
        bus_write(ADDR_DELAY,  32'hDEAD_BEEF);
        bus_write(ADDR_WIDTH,  32'h0001_2345);
        bus_write(ADDR_REPEAT, 32'h0000_0007);
        bus_write(ADDR_PHASE,  32'hFFFF_FFA5);
        bus_write(ADDR_COUNT,  32'h0000_00AA);
        read_expect(ADDR_EN,     32'h0000_0001, "en readback");
        read_expect(ADDR_DELAY,  32'hDEAD_BEEF, "delay readback");
        read_expect(ADDR_WIDTH,  32'h0001_2345, "width readback");
        read_expect(ADDR_REPEAT, 32'h0000_0007, "repeat readback");
        read_expect(ADDR_PHASE,  32'h0000_0005, "phase readback");
        read_expect(ADDR_COUNT,  32'h0000_0000, "count readback");
    endtask

    // ----------------------------------------
    // Stimulus rows
    // ----------------------------------------
    function automatic stim_row_t build_row(input cycle_cnt_t delay, input cycle_cnt_t width,
                                            input cycle_cnt_t repeat_n, input pulse_word_t phase,
                                            input logic use_ext, input logic ext_en);
        stim_row_t row;
        row.delay    = delay;
        row.width    = width;
        row.repeat_n = repeat_n;
        row.phase    = phase;
        row.use_ext  = use_ext;
        row.ext_en   = ext_en;
        return row;
    endfunction

    task automatic apply_row(input stim_row_t row);
        wb_data_t status;
        int       i;
        $display("Row: delay %0d width %0d repeat %0d phase %h ext %0d en %0d",
                 row.delay, row.width, row.repeat_n, row.phase, row.use_ext, row.ext_en);
        bus_write(ADDR_EN,     {31'd0, row.ext_en});
        bus_write(ADDR_DELAY,  row.delay);
        bus_write(ADDR_WIDTH,  row.width);
        bus_write(ADDR_REPEAT, row.repeat_n);
        bus_write(ADDR_PHASE,  {28'd0, row.phase});
        clear_monitor();
        if (row.use_ext) begin
            EXT_START = 1'b1;
        end else begin
            bus_write(ADDR_STATUS, 32'd1);
        end
        if (row.use_ext && !row.ext_en) begin
            // Trigger disabled so nothing may start
            idle_cycles(QUIET_WINDOW);
            EXT_START = 1'b0;
            check_value("nonzero word count", word_count, 32'd0);
            bus_read(ADDR_STATUS, status);
            check_value("status done", status, 32'd1);
        end else begin
            wait_for_bursts(1);
            EXT_START = 1'b0;
            wait_for_done();
            idle_cycles(2);
            check_value("nonzero word count", word_count, row.width * row.repeat_n);
            check_value("burst count", burst_count, row.repeat_n);
            for (i = 0; i < first_words.size(); i++) begin
                check_value("first pulse word", {28'd0, first_words[i]}, {28'd0, row.phase});
            end
            read_expect(ADDR_COUNT, 32'd0, "count after run");
        end
    endtask

    // Repeat 0 runs until a soft reset
    task automatic run_free_and_soft_reset();
        int frozen;
        int i;
        bus_write(ADDR_EN,     32'd0);
        bus_write(ADDR_DELAY,  32'd2);
        bus_write(ADDR_WIDTH,  32'd3);
        bus_write(ADDR_REPEAT, 32'd0);
        bus_write(ADDR_PHASE,  32'h6);
        clear_monitor();
        bus_write(ADDR_STATUS, 32'd1);
        wait_for_bursts(FREE_BURSTS);
        bus_write(ADDR_CTRL, 32'd0);
        idle_cycles(2);
        frozen = word_count;
        idle_cycles(QUIET_WINDOW);
        check_value("word count after soft reset", word_count, frozen);
        check_value("pulse_word", {28'd0, pulse_word}, 32'd0);
        for (i = 0; i < first_words.size(); i++) begin
            check_value("first pulse word", {28'd0, first_words[i]}, 32'h6);
        end
        check_reset_values();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int        i;
        stim_row_t row;
        PULSE_CLK   = 1'b0;
        RST         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        EXT_START   = 1'b0;
        prev_word   = '0;
        clear_monitor();
        void'($urandom(32'h858d));
        repeat (5) @(posedge PULSE_CLK);
        #1;
        RST = 1'b0;

        check_register_access();

        rows.push_back(build_row(32'd1, 32'd1, 32'd1, 4'h5, 1'b0, 1'b0));
        rows.push_back(build_row(32'd3, 32'd4, 32'd1, 4'h9, 1'b0, 1'b0));
        rows.push_back(build_row(32'd2, 32'd3, 32'd3, 4'h3, 1'b0, 1'b0));
        rows.push_back(build_row(32'd5, 32'd2, 32'd2, 4'hC, 1'b1, 1'b1));
        rows.push_back(build_row(32'd2, 32'd2, 32'd1, 4'h7, 1'b1, 1'b0));
        rows.push_back(build_row(32'd1, 32'd3, 32'd4, 4'h1, 1'b0, 1'b1));
        for (i = 0; i < RANDOM_ROWS; i++) begin
            row.delay    = ($urandom % 16) + 1;
            row.width    = ($urandom % 16) + 1;
            row.repeat_n = ($urandom % 3) + 1;
            row.phase    = 4'(($urandom % 15) + 1);
            row.use_ext  = i[0];
            row.ext_en   = i[0];
            rows.push_back(row);
        end

        for (i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end

        run_free_and_soft_reset();

        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #2_000_000;
        stop_run("Simulation watchdog expired");
    end

endmodule

/* source/pulse_gen_top.sv */
`timescale 1ns/10ps

module pulse_gen_top (
    input  logic                       PULSE_CLK,
    input  logic                       RST,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  pulse_gen_pkg::wb_addr_t    wb_adr,
    input  pulse_gen_pkg::wb_data_t    wb_dat_w,
    output pulse_gen_pkg::wb_data_t    wb_dat_r,
    output logic                       wb_ack,
    input  logic                       EXT_START,
    output pulse_gen_pkg::pulse_word_t pulse_word,
    output logic                       pulse_ref
);

    pulse_cfg_if cfg_if ();

    // Wishbone register slave
    pulse_regs regs_i (
        .PULSE_CLK (PULSE_CLK),
        .RST       (RST),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .cfg       (cfg_if.regs)
    );

    // Counters and pulse word shaping
    pulse_seq seq_i (
        .PULSE_CLK  (PULSE_CLK),
        .RST        (RST),
        .EXT_START  (EXT_START),
        .cfg        (cfg_if.seq),
        .pulse_word (pulse_word),
        .pulse_ref  (pulse_ref)
    );

endmodule

/* source/pulse_seq.sv */
`timescale 1ns/10ps

module pulse_seq (
    input  logic                       PULSE_CLK,
    input  logic                       RST,
    input  logic                       EXT_START,
    pulse_cfg_if.seq                   cfg,
    output pulse_gen_pkg::pulse_word_t pulse_word,
    output logic                       pulse_ref
);
    import pulse_gen_pkg::*;

    logic       ext_sync0;
    logic       ext_sync1;
    logic       ext_prev;
    logic       ext_edge;
    logic       clear;
    logic       run_go;
    logic       rerun;
    cycle_cnt_t cycle_cnt;
    cycle_cnt_t rep_cnt;
    cycle_cnt_t last_cnt;
    seq_state_t state;

    // ----------------------------------------
    // External trigger
    // ----------------------------------------
    always_ff @(posedge PULSE_CLK) begin
        if (RST) begin
            ext_sync0 <= 1'b0;
            ext_sync1 <= 1'b0;
            ext_prev  <= 1'b0;
        end else begin
            ext_sync0 <= EXT_START;
            ext_sync1 <= ext_sync0;
            ext_prev  <= ext_sync1;
        end
    end

    assign ext_edge    = ext_sync1 & ~ext_prev;
    assign cfg.ext_run = ext_edge & cfg.en;

    assign clear  = RST | cfg.soft_rst;
    assign run_go = cfg.start | cfg.ext_run;

    // Last count of a period, delay plus width
    assign last_cnt = cfg.delay + cfg.width;

    // Another burst follows; repeat 0 never stops
    assign rerun = (rep_cnt != '0) || (cfg.repeat_n == '0);

    assign cfg.done = (cycle_cnt == '0);
    assign cfg.cnt  = cycle_cnt;

    // ----------------------------------------
    // Sequencer FSM
    // ----------------------------------------
    always_ff @(posedge PULSE_CLK) begin
        if (clear) begin
            state      <= IDLE;
            cycle_cnt  <= '0;
            rep_cnt    <= '0;
            pulse_word <= '0;
            pulse_ref  <= 1'b0;
        end else if (run_go) begin
            // Also restarts a run already in progress
            state      <= DELAY;
            cycle_cnt  <= 32'd1;
            rep_cnt    <= cfg.repeat_n;
            pulse_word <= '0;
            pulse_ref  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    pulse_word <= '0;
                    pulse_ref  <= 1'b0;
                end
                DELAY, GAP: begin
                    cycle_cnt <= cycle_cnt + 32'd1;
                    if (cycle_cnt == 32'd1 && rep_cnt != '0) begin
                        rep_cnt <= rep_cnt - 32'd1;
                    end
                    if (cycle_cnt == cfg.delay) begin
                        // First word carries the fine phase
                        state      <= PULSE;
                        pulse_word <= cfg.phase;
                        pulse_ref  <= 1'b1;
                    end
                end
                PULSE: begin
                    if (cycle_cnt == last_cnt) begin
                        pulse_word <= '0;
                        pulse_ref  <= 1'b0;
                        if (rerun) begin
                            state     <= GAP;
                            cycle_cnt <= 32'd1;
                        end else begin
                            state     <= IDLE;
                            cycle_cnt <= '0;
                        end
                    end else begin
                        cycle_cnt  <= cycle_cnt + 32'd1;
                        pulse_word <= PULSE_ONES;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    cnt_in_period: assert property (
        @(posedge PULSE_CLK) disable iff (RST)
        cycle_cnt <= last_cnt
    );

    ref_low_idle: assert property (
        @(posedge PULSE_CLK) disable iff (RST)
        (state == IDLE) |-> !pulse_ref
    );

endmodule

/* source/pulse_regs.sv */
`timescale 1ns/10ps

module pulse_regs (
    input  logic                    PULSE_CLK,
    input  logic                    RST,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  pulse_gen_pkg::wb_addr_t wb_adr,
    input  pulse_gen_pkg::wb_data_t wb_dat_w,
    output pulse_gen_pkg::wb_data_t wb_dat_r,
    output logic                    wb_ack,
    pulse_cfg_if.regs               cfg
);
    import pulse_gen_pkg::*;

    logic wb_req;
    logic wr_en;
    logic status_done;

    // New request only while no ack is pending
    assign wb_req = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en  = wb_req & wb_we;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------
    always_ff @(posedge PULSE_CLK) begin
        if (RST) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // Read data lands at the ack edge
    always_ff @(posedge PULSE_CLK) begin
        if (wb_req) begin
            case (wb_adr)
                ADDR_CTRL:   wb_dat_r <= VERSION;
                ADDR_STATUS: wb_dat_r <= {31'd0, status_done};
                ADDR_EN:     wb_dat_r <= {31'd0, cfg.en};
                ADDR_DELAY:  wb_dat_r <= cfg.delay;
                ADDR_WIDTH:  wb_dat_r <= cfg.width;
                ADDR_REPEAT: wb_dat_r <= cfg.repeat_n;
                ADDR_PHASE:  wb_dat_r <= {28'd0, cfg.phase};
                ADDR_COUNT:  wb_dat_r <= cfg.cnt;
                default:     wb_dat_r <= '0;
            endcase
        end
    end

    // ----------------------------------------
    // Strobes
    // ----------------------------------------
    always_ff @(posedge PULSE_CLK) begin
        if (RST) begin
            cfg.start    <= 1'b0;
            cfg.soft_rst <= 1'b0;
        end else begin
            cfg.start    <= wr_en && (wb_adr == ADDR_STATUS);
            cfg.soft_rst <= wr_en && (wb_adr == ADDR_CTRL);
        end
    end

    // ----------------------------------------
    // Configuration registers
    // ----------------------------------------
    always_ff @(posedge PULSE_CLK) begin
        if (RST || cfg.soft_rst) begin
            cfg.en       <= 1'b0;
            cfg.delay    <= '0;
            cfg.width    <= '0;
            cfg.repeat_n <= RESET_REPEAT;
            cfg.phase    <= '0;
        end else if (wr_en) begin
            case (wb_adr)
                ADDR_EN:     cfg.en       <= wb_dat_w[0];
                ADDR_DELAY:  cfg.delay    <= wb_dat_w;
                ADDR_WIDTH:  cfg.width    <= wb_dat_w;
                ADDR_REPEAT: cfg.repeat_n <= wb_dat_w;
                ADDR_PHASE:  cfg.phase    <= wb_dat_w[3:0];
                default: begin
                end
            endcase
        end
    end

    // Done status, cleared by either kind of run start
    always_ff @(posedge PULSE_CLK) begin
        if (RST || cfg.soft_rst) begin
            status_done <= 1'b1;
        end else if (cfg.start || cfg.ext_run) begin
            status_done <= 1'b0;
        end else if (cfg.done) begin
            status_done <= 1'b1;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    ack_single_cycle: assert property (
        @(posedge PULSE_CLK) disable iff (RST)
        wb_ack |=> !wb_ack
    );

    // Ack must answer a request seen on the previous edge
    ack_after_req: assert property (
        @(posedge PULSE_CLK) disable iff (RST)
        wb_ack |-> $past(wb_cyc && wb_stb)
    );

endmodule

/* source/pulse_cfg_if.sv */
`timescale 1ns/10ps

interface pulse_cfg_if;
    import pulse_gen_pkg::*;

    // Register block to sequencer
    logic        en;
    cycle_cnt_t  delay;
    cycle_cnt_t  width;
    cycle_cnt_t  repeat_n;
    pulse_word_t phase;
    logic        start;
    logic        soft_rst;

    // Sequencer back to register block
    logic        done;
    cycle_cnt_t  cnt;
    logic        ext_run;

    modport regs (
        output en, delay, width, repeat_n, phase, start, soft_rst,
        input  done, cnt, ext_run
    );

    modport seq (
        input  en, delay, width, repeat_n, phase, start, soft_rst,
        output done, cnt, ext_run
    );

endinterface

/* source/pulse_gen_pkg.sv */
package pulse_gen_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    typedef logic [2:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [31:0] cycle_cnt_t;

    // Four fine slices per PULSE_CLK cycle, slice 0 goes out first
    typedef logic [3:0]  pulse_word_t;

    // ----------------------------------------
    // Sequencer states
    // ----------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        DELAY,
        PULSE,
        GAP
    } seq_state_t;

    // ----------------------------------------
    // Register map (word addresses)
    // ----------------------------------------
    localparam wb_data_t VERSION = 32'd1;

    localparam wb_addr_t ADDR_CTRL   = 3'd0;  // read version, write soft reset
    localparam wb_addr_t ADDR_STATUS = 3'd1;  // read done, write start
    localparam wb_addr_t ADDR_EN     = 3'd2;
    localparam wb_addr_t ADDR_DELAY  = 3'd3;
    localparam wb_addr_t ADDR_WIDTH  = 3'd4;
    localparam wb_addr_t ADDR_REPEAT = 3'd5;
    localparam wb_addr_t ADDR_PHASE  = 3'd6;
    localparam wb_addr_t ADDR_COUNT  = 3'd7;  // read only

    localparam cycle_cnt_t RESET_REPEAT = 32'd1;

    // Body of a pulse after the phase word
    localparam pulse_word_t PULSE_ONES = 4'hF;

endpackage
